// ==== include/periph_consts.svh ====
/*
  Widths and register map of the peripheral hub.
  GPIO offsets are byte offsets inside a 64-byte user slot.
  A function select code has the region in bit 4 and the slot in bits 3:0.
*/
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Core bus
`define PERIPH_ADDR_W 11
`define PERIPH_DATA_W 32

// Address bit that separates the user and simple regions
`define PERIPH_REGION_BIT 10

// Output pins and slots per region
`define PERIPH_PINS 8
`define PERIPH_SLOTS 16

// Pin function select width
`define PERIPH_SEL_W 5

// GPIO block placement and register offsets
`define GPIO_SLOT 4'd1
`define GPIO_OUT_OFS 6'h00
`define GPIO_IN_OFS 6'h04
`define GPIO_SEL_BASE 6'h20

// Pins 0 and 1 start on user slot 2, the rest on the GPIO
`define GPIO_SEL_RESET_LO 5'd2
`define GPIO_SEL_RESET 5'd1

`endif

// ==== rtl/periph_pkg.sv ====
/*
  Shared types of the peripheral hub.
  Access size codes follow the core encoding, where 11 means idle.
  The request struct carries one decoded access for a single cycle.
*/
`default_nettype none

`include "periph_consts.svh"

package periph_pkg;

    // Two-bit size code of the core's read and write strobes
    typedef enum logic [1:0] {
        XFER_BYTE = 2'b00,
        XFER_HALF = 2'b01,
        XFER_WORD = 2'b10,
        XFER_NONE = 2'b11
    } xfer_size_e;

    // Address region, taken from the region bit
    typedef enum logic {
        REGION_USER   = 1'b0,
        REGION_SIMPLE = 1'b1
    } region_e;

    // Decoded access
    // In the simple region only offset[3:0] carries address bits
    typedef struct packed {
        region_e                          region;
        logic [$clog2(`PERIPH_SLOTS)-1:0] slot;
        logic [5:0]                       offset;
        logic                             wr;
        logic                             rd;
        logic [`PERIPH_DATA_W-1:0]        wdata;
    } periph_req_t;

endpackage

`default_nettype wire

// ==== rtl/periph_decode.sv ====
/*
  Address and strobe decode of the peripheral hub.
  User slots are 64 bytes (addr[9:6]), simple slots 16 bytes (addr[7:4]).
  Purely combinational. The core must not touch 0x300 to 0x3FF.
*/
`default_nettype none

`include "periph_consts.svh"

module periph_decode (
    input  wire logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  wire logic [`PERIPH_DATA_W-1:0] i_wdata,
    input  wire periph_pkg::xfer_size_e    i_write_n,
    input  wire periph_pkg::xfer_size_e    i_read_n,
    output periph_pkg::periph_req_t        o_req
);
    import periph_pkg::*;

    logic in_simple;
    logic strobe;
    logic reserved_hit;

    assign in_simple = i_addr[`PERIPH_REGION_BIT];
    assign strobe    = (i_write_n != XFER_NONE) || (i_read_n != XFER_NONE);

    always_comb begin
        o_req.region = in_simple ? REGION_SIMPLE : REGION_USER;
        if (in_simple) begin
            // Bits 9:8 are ignored in the simple region
            o_req.slot   = i_addr[7:4];
            o_req.offset = {2'b00, i_addr[3:0]};
        end else begin
            o_req.slot   = i_addr[9:6];
            o_req.offset = i_addr[5:0];
        end
        o_req.wr    = i_write_n != XFER_NONE;
        o_req.rd    = i_read_n != XFER_NONE;
        o_req.wdata = i_wdata;
    end

    // Top quarter of the user region is kept free by the core
    assign reserved_hit = strobe && (i_addr[10:8] == 3'b011);

    always_comb begin
        a_no_reserved: assert final (reserved_hit !== 1'b1)
            else $error("Core access to reserved address 0x%03h", i_addr);
    end

endmodule

`default_nettype wire

// ==== rtl/gpio_ctrl.sv ====
/*
  GPIO block in user slot 1 and the per-pin output multiplexer.
  Only the low byte of a write is used, whatever the access size.
  Unused user slots drive zero on the pins they are selected for.
*/
`default_nettype none

`include "periph_consts.svh"

module gpio_ctrl (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,
    input  wire periph_pkg::periph_req_t                 i_req,
    input  wire logic [`PERIPH_PINS-1:0]                 i_ui_in,
    input  wire logic [`PERIPH_SLOTS-1:0][`PERIPH_PINS-1:0] i_simple_pins,
    output logic [`PERIPH_DATA_W-1:0]                    o_rdata,
    output logic [`PERIPH_PINS-1:0]                      o_uo_out
);
    import periph_pkg::*;

    logic [`PERIPH_PINS-1:0]                    gpio_out_q;
    logic [`PERIPH_PINS-1:0][`PERIPH_SEL_W-1:0] func_sel_q;
    logic                                       gpio_hit;
    logic                                       out_hit;
    logic                                       in_hit;
    logic                                       sel_hit;
    logic [$clog2(`PERIPH_PINS)-1:0]            sel_idx;
    logic                                       sel_wr;

    assign gpio_hit = (i_req.region == REGION_USER) && (i_req.slot == `GPIO_SLOT);
    assign out_hit  = i_req.offset == `GPIO_OUT_OFS;
    assign in_hit   = i_req.offset == `GPIO_IN_OFS;

    // One word per pin from the select base to the end of the slot
    assign sel_hit = (i_req.offset >= `GPIO_SEL_BASE) && (i_req.offset[1:0] == 2'b00);
    // Base has bits 4:2 clear, so these bits index the pin directly
    assign sel_idx = i_req.offset[4:2];
    assign sel_wr  = gpio_hit && i_req.wr && sel_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
        end else if (gpio_hit && i_req.wr && out_hit) begin
            gpio_out_q <= i_req.wdata[`PERIPH_PINS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PERIPH_PINS; i++) begin
                func_sel_q[i] <= (i < 2) ? `GPIO_SEL_RESET_LO : `GPIO_SEL_RESET;
            end
        end else if (sel_wr) begin
            func_sel_q[sel_idx] <= i_req.wdata[`PERIPH_SEL_W-1:0];
        end
    end

    // Read word is zero for other slots and unmapped offsets
    always_comb begin
        o_rdata = '0;
        if (gpio_hit) begin
            if (out_hit) begin
                o_rdata[`PERIPH_PINS-1:0] = gpio_out_q;
            end else if (in_hit) begin
                o_rdata[`PERIPH_PINS-1:0] = i_ui_in;
            end else if (sel_hit) begin
                o_rdata[`PERIPH_SEL_W-1:0] = func_sel_q[sel_idx];
            end
        end
    end

    // Pin mux
    // Select bit 4 picks a simple slot, otherwise only the GPIO slot drives
    always_comb begin
        for (int i = 0; i < `PERIPH_PINS; i++) begin
            if (func_sel_q[i][`PERIPH_SEL_W-1]) begin
                o_uo_out[i] = i_simple_pins[func_sel_q[i][3:0]][i];
            end else if (func_sel_q[i][3:0] == `GPIO_SLOT) begin
                o_uo_out[i] = gpio_out_q[i];
            end else begin
                o_uo_out[i] = 1'b0;
            end
        end
    end

    // Pin routing only moves on a decoded select write
    a_sel_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        !sel_wr |=> $stable(func_sel_q)
    ) else $error("Function select changed without a GPIO select write");

endmodule

`default_nettype wire

// ==== rtl/simple_slot_bank.sv ====
/*
  Bank of sixteen minimal simple peripherals, one byte register each.
  The register sits at offset 0 and drives the slot's eight pin outputs.
  Other offsets read as zero and ignore writes.
*/
`default_nettype none

`include "periph_consts.svh"

module simple_slot_bank (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,
    input  wire periph_pkg::periph_req_t                 i_req,
    output logic [7:0]                                   o_rbyte,
    output logic [`PERIPH_SLOTS-1:0][`PERIPH_PINS-1:0]   o_pins
);
    import periph_pkg::*;

    logic [`PERIPH_SLOTS-1:0][7:0] slot_q;
    logic [`PERIPH_SLOTS-1:0]      slot_we;
    logic                          reg_hit;

    assign reg_hit = i_req.offset[3:0] == 4'h0;

    genvar s;
    generate
        for (s = 0; s < `PERIPH_SLOTS; s++) begin : g_slot
            // Byte write to this slot's register
            assign slot_we[s] = (i_req.region == REGION_SIMPLE) && i_req.wr && reg_hit
                                && (i_req.slot == s);

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    slot_q[s] <= 8'h00;
                end else if (slot_we[s]) begin
                    slot_q[s] <= i_req.wdata[7:0];
                end
            end

            assign o_pins[s] = slot_q[s];
        end
    endgenerate

    // Region is picked later in the read return
    assign o_rbyte = reg_hit ? slot_q[i_req.slot] : 8'h00;

endmodule

`default_nettype wire

// ==== rtl/read_return.sv ====
/*
  Registered read return towards the core.
  Data is captured one cycle after the read is seen and held until
  read complete. The core drops the read before the next one starts.
  Write ready is combinational.
*/
`default_nettype none

`include "periph_consts.svh"

module read_return (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire periph_pkg::periph_req_t   i_req,
    input  wire logic [`PERIPH_DATA_W-1:0] i_gpio_rdata,
    input  wire logic [7:0]                i_simple_rbyte,
    input  wire periph_pkg::xfer_size_e    i_write_n,
    input  wire logic                      i_read_complete,
    output logic [`PERIPH_DATA_W-1:0]      o_rdata,
    output logic                           o_ready
);
    import periph_pkg::*;

    logic                      hold_q;
    logic                      ready_q;
    logic [`PERIPH_DATA_W-1:0] rdata_q;
    logic [`PERIPH_DATA_W-1:0] read_word;
    logic                      capture;

    // Simple peripherals return a byte, zero-extended
    assign read_word = (i_req.region == REGION_SIMPLE)
                       ? {{(`PERIPH_DATA_W-8){1'b0}}, i_simple_rbyte}
                       : i_gpio_rdata;

    assign capture = i_req.rd && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (capture) begin
                hold_q <= 1'b1;
            end else if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            // Ready follows the read a cycle late, matching the data register
            ready_q <= i_req.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_q <= read_word;
        end
    end

    assign o_rdata = rdata_q;
    assign o_ready = ready_q || (i_write_n != XFER_NONE);

    // Returned data stays frozen until the core releases it
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        hold_q |=> $stable(o_rdata)
    ) else $error("Read data changed while held");

endmodule

`default_nettype wire

// ==== rtl/periph_hub.sv ====
/*
  Peripheral hub of the microcontroller.
  User slot 1 holds the GPIO, other user slots are empty and read zero.
  Each simple slot holds one byte register at offset 0.
  Every target answers at once, so there is no back-pressure.
*/
`default_nettype none

`include "periph_consts.svh"

module periph_hub (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic [`PERIPH_PINS-1:0]   i_ui_in,
    input  wire logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  wire logic [`PERIPH_DATA_W-1:0] i_wdata,
    input  wire periph_pkg::xfer_size_e    i_write_n,
    input  wire periph_pkg::xfer_size_e    i_read_n,
    input  wire logic                      i_read_complete,
    output logic [`PERIPH_DATA_W-1:0]      o_rdata,
    output logic                           o_ready,
    output logic [`PERIPH_PINS-1:0]        o_uo_out
);
    import periph_pkg::*;

    periph_req_t                              req;
    logic [`PERIPH_DATA_W-1:0]                gpio_rdata;
    logic [7:0]                               simple_rbyte;
    logic [`PERIPH_SLOTS-1:0][`PERIPH_PINS-1:0] simple_pins;

    periph_decode u_decode (
        .i_addr    (i_addr),
        .i_wdata   (i_wdata),
        .i_write_n (i_write_n),
        .i_read_n  (i_read_n),
        .o_req     (req)
    );

    gpio_ctrl u_gpio (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_req         (req),
        .i_ui_in       (i_ui_in),
        .i_simple_pins (simple_pins),
        .o_rdata       (gpio_rdata),
        .o_uo_out      (o_uo_out)
    );

    simple_slot_bank u_simple (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_req   (req),
        .o_rbyte (simple_rbyte),
        .o_pins  (simple_pins)
    );

    read_return u_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (req),
        .i_gpio_rdata    (gpio_rdata),
        .i_simple_rbyte  (simple_rbyte),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .o_rdata         (o_rdata),
        .o_ready         (o_ready)
    );

endmodule

`default_nettype wire

// ==== tests/periph_hub_tb.sv ====
/*
  Testbench of the peripheral hub, driven from tests/periph_hub_cases.txt.
  Run from the project root so that the case file path resolves.
  Reads hold the strobe until ready, then pulse read complete.
  Random cases only make sense on the GPIO input readback address.
*/
`default_nettype none

`include "periph_consts.svh"

module periph_hub_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import periph_pkg::*;

    localparam int    MAX_CASES  = 64;
    localparam int    READY_WAIT = 4;
    localparam string CASE_FILE  = "tests/periph_hub_cases.txt";

    localparam logic [3:0] OP_WRITE = 4'h1;
    localparam logic [3:0] OP_READ  = 4'h2;
    localparam logic [3:0] OP_HOLD  = 4'h3;
    localparam logic [3:0] OP_PINS  = 4'h4;

    // One line of the case file
    typedef struct packed {
        logic [3:0]  op;
        logic [11:0] addr;
        logic [7:0]  data;
        logic [31:0] exp_val;
        logic [3:0]  rnd;
    } case_t;

    logic                      clk;
    logic                      rst_n;
    logic [`PERIPH_PINS-1:0]   ui_in;
    logic [`PERIPH_ADDR_W-1:0] addr;
    logic [`PERIPH_DATA_W-1:0] wdata;
    xfer_size_e                write_n;
    xfer_size_e                read_n;
    logic                      read_complete;
    logic [`PERIPH_DATA_W-1:0] rdata;
    logic                      ready;
    logic [`PERIPH_PINS-1:0]   uo_out;

    logic [59:0] case_mem [0:MAX_CASES-1];
    int          case_count;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    integer      seed = 32'h4c6a2f0b;

    periph_hub dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .i_addr          (addr),
        .i_wdata         (wdata),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .o_rdata         (rdata),
        .o_ready         (ready),
        .o_uo_out        (uo_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("Error: %s", why);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns %s: got 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_cases();
        for (int i = 0; i < MAX_CASES; i++) begin
            case_mem[i] = '0;
        end
        $readmemh(CASE_FILE, case_mem);
        case_count = 0;
        // An all-zero entry ends the list
        while (case_count < MAX_CASES && case_mem[case_count][59:56] != 4'h0) begin
            case_count++;
        end
        if (case_count == 0) begin
            abort_run("no cases were loaded from the case file");
        end
        cycle_limit = 16 + 10 * case_count + 100;
    endtask

    // Tasks start and end one drive delay after a rising edge
    task automatic write_byte(input logic [`PERIPH_ADDR_W-1:0] a, input logic [7:0] d);
        addr    = a;
        wdata   = {24'h0, d};
        write_n = XFER_BYTE;
        @(negedge clk);
        check_value("o_ready", {31'b0, ready}, 32'd1);
        @(posedge clk);
        #1;
        write_n = XFER_NONE;
    endtask

    task automatic read_word(input logic [`PERIPH_ADDR_W-1:0] a, input logic [7:0] ui_val,
                             input logic [7:0] hold_ui, input logic [31:0] expected);
        int waited;
        waited  = 0;
        ui_in   = ui_val;
        addr    = a;
        read_n  = XFER_WORD;
        @(negedge clk);
        while (ready !== 1'b1) begin
            if (waited == READY_WAIT) begin
                abort_run("o_ready never came for a read");
            end
            waited++;
            @(negedge clk);
        end
        check_value("o_rdata", rdata, expected);
        // Input may move while the result is held
        @(posedge clk);
        #1;
        ui_in = hold_ui;
        @(posedge clk);
        @(negedge clk);
        check_value("o_rdata", rdata, expected);
        check_value("o_ready", {31'b0, ready}, 32'd1);
        @(posedge clk);
        #1;
        read_n        = XFER_NONE;
        read_complete = 1'b1;
        @(posedge clk);
        #1;
        read_complete = 1'b0;
    endtask

    task automatic check_pins(input logic [7:0] ui_val, input logic [31:0] expected);
        ui_in = ui_val;
        @(negedge clk);
        check_value("o_uo_out", {24'h0, uo_out}, expected);
        @(posedge clk);
        #1;
    endtask

    task automatic run_case(input case_t c);
        logic [7:0]  ui_val;
        logic [31:0] exp_val;
        logic [31:0] rnd_word;
        ui_val  = c.data;
        exp_val = c.exp_val;
        if (c.rnd != 4'h0) begin
            // GPIO input readback returns the applied byte
            rnd_word = $random(seed);
            ui_val   = rnd_word[7:0];
            exp_val  = {24'h0, ui_val};
        end
        case (c.op)
            OP_WRITE: write_byte(c.addr[`PERIPH_ADDR_W-1:0], c.data);
            OP_READ:  read_word(c.addr[`PERIPH_ADDR_W-1:0], ui_val, ui_val, exp_val);
            OP_HOLD:  read_word(c.addr[`PERIPH_ADDR_W-1:0], ui_in, c.data, exp_val);
            OP_PINS:  check_pins(ui_val, exp_val);
            default:  abort_run("unknown operation in the case file");
        endcase
    endtask

    // Watchdog sized from the case count
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Error: the run timed out after %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        wdata         = '0;
        write_n       = XFER_NONE;
        read_n        = XFER_NONE;
        read_complete = 1'b0;
        load_cases();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < case_count; i++) begin
            run_case(case_t'(case_mem[i]));
        end
        @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== periph_hub.f ====
+incdir+include
rtl/periph_pkg.sv
rtl/periph_decode.sv
rtl/gpio_ctrl.sv
rtl/simple_slot_bank.sv
rtl/read_return.sv
rtl/periph_hub.sv
tests/periph_hub_tb.sv

// ==== tests/periph_hub_cases.txt ====
// Columns: op_addr_data_expect_rand, all hex
// op 1 byte write, 2 read with ui_in = data, 3 read whose ui_in moves to data while held
// op 4 pin check with ui_in = data; rand 1 puts a random byte on ui_in for a read
// Reset values
4_000_00_00000000_0
2_060_00_00000002_0
2_074_00_00000001_0
2_040_00_00000000_0
// GPIO output and input
1_040_A5_00000000_0
2_040_00_000000A5_0
4_000_00_000000A4_0
2_044_5A_0000005A_0
2_044_00_00000000_1
2_044_00_00000000_1
2_048_00_00000000_0
// Function select routing through simple slot 3
1_430_3C_00000000_0
2_430_00_0000003C_0
1_060_13_00000000_0
2_060_00_00000013_0
4_000_00_000000A4_0
1_06C_13_00000000_0
4_000_00_000000AC_0
// Pin 5 on empty user slot 5
1_074_05_00000000_0
2_074_00_00000005_0
4_000_00_0000008C_0
// Simple region
1_400_11_00000000_0
1_470_C7_00000000_0
1_4F0_E2_00000000_0
2_400_00_00000011_0
2_470_00_000000C7_0
2_4F0_00_000000E2_0
2_430_00_0000003C_0
2_410_00_00000000_0
1_474_99_00000000_0
2_474_00_00000000_0
2_470_00_000000C7_0
2_080_00_00000000_0
2_0C4_00_00000000_0
1_078_17_00000000_0
2_078_00_00000017_0
4_000_FF_000000CC_0
// Read hold
2_044_33_00000033_0
3_044_CC_00000033_0
2_044_CC_000000CC_0
2_040_00_000000A5_0
